// ==== rtl/evict_pkg.sv ====
package evict_pkg;

	localparam int ADDR_W          = 32;	// Line address width
	localparam int DATA_W          = 64;	// Line data width, scaled model
	localparam int FIFO_DEPTH      = 4;	// Entries per FIFO
	localparam int MAX_OUTSTANDING = 3;	// AW accepted, B not yet seen
	localparam int CNT_W           = 2;	// Outstanding counter width

	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [DATA_W-1:0] data_t;

	// Cache-side eviction payload
	typedef struct packed {
		addr_t addr;	// Line address
		data_t data;	// Dirty line data
	} evict_req_t;

	// AXI write response codes
	typedef enum logic [1:0] {
		OKAY   = 2'b00,
		EXOKAY = 2'b01,
		SLVERR = 2'b10,
		DECERR = 2'b11
	} bresp_t;

endpackage

// ==== rtl/evict_fifo.sv ====
`timescale 1ns/10ps

module evict_fifo #(
	parameter int WIDTH = 8,
	parameter int DEPTH = evict_pkg::FIFO_DEPTH
) (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             push_i,
	input  logic [WIDTH-1:0] push_data_i,
	input  logic             pop_i,
	output logic [WIDTH-1:0] head_o,
	output logic             empty_o,
	output logic             full_o
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	logic [WIDTH-1:0] mem [DEPTH];	// Storage, no reset needed
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;	// Occupancy
	logic             wr_en;
	logic             rd_en;

	assign wr_en = push_i & ~full_o;	// Push while full is dropped
	assign rd_en = pop_i & ~empty_o;

	assign empty_o = (count == '0);
	assign full_o  = (count == CNT_W'(DEPTH));

	// First word falls through
	assign head_o = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_ptr] <= push_data_i;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (wr_en) begin
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (rd_en) begin
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			case ({wr_en, rd_en})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;	// Both or neither, level unchanged
			endcase
		end
	end

endmodule

// ==== rtl/evict_queue.sv ====
`timescale 1ns/10ps

module evict_queue (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 evict_i,
	input  evict_pkg::evict_req_t evict_req_i,
	output logic                 evict_full_o,
	input  logic                 awfifo_rden_i,
	output logic                 awfifo_empty_o,
	output evict_pkg::addr_t     awfifo_data_o,
	input  logic                 wfifo_rden_i,
	output logic                 wfifo_empty_o,
	output evict_pkg::data_t     wfifo_data_o
);

	import evict_pkg::*;

	logic aw_full;
	logic w_full;
	logic push;

	// Both FIFOs push together so the entries stay paired
	assign push         = evict_i & ~aw_full & ~w_full;
	assign evict_full_o = aw_full | w_full;

	evict_fifo #(
		.WIDTH (ADDR_W),
		.DEPTH (FIFO_DEPTH)
	) u_aw_fifo (
		.clk         (clk),
		.rst_n       (rst_n),
		.push_i      (push),
		.push_data_i (evict_req_i.addr),
		.pop_i       (awfifo_rden_i),
		.head_o      (awfifo_data_o),
		.empty_o     (awfifo_empty_o),
		.full_o      (aw_full)
	);

	evict_fifo #(
		.WIDTH (DATA_W),
		.DEPTH (FIFO_DEPTH)
	) u_w_fifo (
		.clk         (clk),
		.rst_n       (rst_n),
		.push_i      (push),
		.push_data_i (evict_req_i.data),
		.pop_i       (wfifo_rden_i),
		.head_o      (wfifo_data_o),
		.empty_o     (wfifo_empty_o),
		.full_o      (w_full)
	);

endmodule

// ==== rtl/evict_aw_w.sv ====
`timescale 1ns/10ps

module evict_aw_w (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             awfifo_empty_i,
	input  evict_pkg::addr_t awfifo_data_i,
	output logic             awfifo_rden_o,
	input  logic             wfifo_empty_i,
	input  evict_pkg::data_t wfifo_data_i,
	output logic             wfifo_rden_o,
	input  logic             credit_i,
	output evict_pkg::addr_t awaddr_o,
	output logic             awvalid_o,
	input  logic             awready_i,
	output evict_pkg::data_t wdata_o,
	output logic             wvalid_o,
	input  logic             wready_i,
	output logic             aw_fire_o,
	output logic             busy_o
);

	import evict_pkg::*;

	typedef enum logic {
		S_IDLE = 1'b0,
		S_RUN  = 1'b1
	} state_t;

	state_t state;
	state_t state_n;
	addr_t  awaddr_q;	// Captured at pop, held through RUN
	data_t  wdata_q;
	logic   aw_done_q;	// AW already accepted in this issue
	logic   w_done_q;	// W already accepted in this issue
	logic   start;
	logic   aw_fire;
	logic   w_fire;
	logic   aw_all;
	logic   w_all;

	// Need a full pair and a free credit to issue
	assign start = (state == S_IDLE) & ~awfifo_empty_i & ~wfifo_empty_i & credit_i;

	assign awfifo_rden_o = start;
	assign wfifo_rden_o  = start;

	assign awvalid_o = (state == S_RUN) & ~aw_done_q;
	assign wvalid_o  = (state == S_RUN) & ~w_done_q;
	assign awaddr_o  = awaddr_q;
	assign wdata_o   = wdata_q;

	assign aw_fire = awvalid_o & awready_i;
	assign w_fire  = wvalid_o & wready_i;
	assign aw_all  = aw_done_q | aw_fire;	// Done now or earlier
	assign w_all   = w_done_q | w_fire;

	assign aw_fire_o = aw_fire;
	assign busy_o    = (state == S_RUN);

	always_comb begin
		state_n = state;
		case (state)
			S_IDLE: begin
				if (start) begin
					state_n = S_RUN;
				end
			end
			S_RUN: begin
				if (aw_all & w_all) begin	// Either channel order
					state_n = S_IDLE;
				end
			end
			default: state_n = S_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state     <= S_IDLE;
			aw_done_q <= 1'b0;
			w_done_q  <= 1'b0;
		end else begin
			state <= state_n;
			if (state == S_RUN && !(aw_all && w_all)) begin
				aw_done_q <= aw_all;
				w_done_q  <= w_all;
			end else begin
				aw_done_q <= 1'b0;	// Cleared for the next issue
				w_done_q  <= 1'b0;
			end
		end
	end

	// Payload registers
	always_ff @(posedge clk) begin
		if (start) begin
			awaddr_q <= awfifo_data_i;
			wdata_q  <= wfifo_data_i;
		end
	end

endmodule

// ==== rtl/evict_bresp.sv ====
`timescale 1ns/10ps

module evict_bresp (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              aw_fire_i,
	input  logic              bvalid_i,
	input  evict_pkg::bresp_t bresp_i,
	output logic              bready_o,
	output logic              credit_o,
	output logic              wr_done_o,
	output logic              wr_err_o,
	output logic              pending_o
);

	import evict_pkg::*;

	logic [CNT_W-1:0] out_cnt;	// Writes awaiting a B response
	logic             live_q;	// High from the first cycle after reset
	logic             done_q;
	logic             err_q;
	logic             b_fire;
	logic             resp_ok;

	// Held low while a pulse is registered, one response per two cycles
	assign bready_o = live_q & ~done_q & ~err_q;
	assign b_fire   = bvalid_i & bready_o;
	assign resp_ok  = (bresp_i == OKAY) || (bresp_i == EXOKAY);

	assign credit_o  = (out_cnt < CNT_W'(MAX_OUTSTANDING));
	assign pending_o = (out_cnt != '0);
	assign wr_done_o = done_q;
	assign wr_err_o  = err_q;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			out_cnt <= '0;
			live_q  <= 1'b0;
			done_q  <= 1'b0;
			err_q   <= 1'b0;
		end else begin
			live_q <= 1'b1;
			done_q <= b_fire & resp_ok;
			err_q  <= b_fire & ~resp_ok;	// SLVERR or DECERR
			case ({aw_fire_i, b_fire})
				2'b10:   out_cnt <= out_cnt + 1'b1;
				2'b01:   out_cnt <= out_cnt - 1'b1;
				default: out_cnt <= out_cnt;	// Issue and retire cancel
			endcase
		end
	end

endmodule

// ==== rtl/evict_top.sv ====
`timescale 1ns/10ps

module evict_top (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  evict_i,
	input  evict_pkg::evict_req_t evict_req_i,
	output logic                  evict_full_o,
	output evict_pkg::addr_t      awaddr_o,
	output logic                  awvalid_o,
	input  logic                  awready_i,
	output evict_pkg::data_t      wdata_o,
	output logic                  wvalid_o,
	input  logic                  wready_i,
	input  logic                  bvalid_i,
	input  evict_pkg::bresp_t     bresp_i,
	output logic                  bready_o,
	output logic                  wr_done_o,
	output logic                  wr_err_o,
	output logic                  idle_o
);

	import evict_pkg::*;

	addr_t aw_head;
	data_t w_head;
	logic  aw_empty;
	logic  w_empty;
	logic  aw_rden;
	logic  w_rden;
	logic  credit;
	logic  aw_fire;
	logic  busy;
	logic  pending;

	// Nothing queued, nothing issuing, nothing outstanding
	assign idle_o = aw_empty & w_empty & ~busy & ~pending;

	evict_queue u_queue (
		.clk            (clk),
		.rst_n          (rst_n),
		.evict_i        (evict_i),
		.evict_req_i    (evict_req_i),
		.evict_full_o   (evict_full_o),
		.awfifo_rden_i  (aw_rden),
		.awfifo_empty_o (aw_empty),
		.awfifo_data_o  (aw_head),
		.wfifo_rden_i   (w_rden),
		.wfifo_empty_o  (w_empty),
		.wfifo_data_o   (w_head)
	);

	evict_aw_w u_aw_w (
		.clk            (clk),
		.rst_n          (rst_n),
		.awfifo_empty_i (aw_empty),
		.awfifo_data_i  (aw_head),
		.awfifo_rden_o  (aw_rden),
		.wfifo_empty_i  (w_empty),
		.wfifo_data_i   (w_head),
		.wfifo_rden_o   (w_rden),
		.credit_i       (credit),
		.awaddr_o       (awaddr_o),
		.awvalid_o      (awvalid_o),
		.awready_i      (awready_i),
		.wdata_o        (wdata_o),
		.wvalid_o       (wvalid_o),
		.wready_i       (wready_i),
		.aw_fire_o      (aw_fire),
		.busy_o         (busy)
	);

	evict_bresp u_bresp (
		.clk       (clk),
		.rst_n     (rst_n),
		.aw_fire_i (aw_fire),
		.bvalid_i  (bvalid_i),
		.bresp_i   (bresp_i),
		.bready_o  (bready_o),
		.credit_o  (credit),
		.wr_done_o (wr_done_o),
		.wr_err_o  (wr_err_o),
		.pending_o (pending)
	);

endmodule

// ==== test/evict_tb.sv ====
`timescale 1ns/10ps

module evict_tb;

	import evict_pkg::*;

	localparam int NUM_EVICT = 200;
	localparam int TIMEOUT   = 2000;	// Cycles per wait

	logic       clk;
	logic       rst_n;
	logic       evict;
	evict_req_t evict_req;
	logic       evict_full;
	addr_t      awaddr;
	logic       awvalid;
	logic       awready;
	data_t      wdata;
	logic       wvalid;
	logic       wready;
	logic       bvalid;
	bresp_t     bresp;
	logic       bready;
	logic       wr_done;
	logic       wr_err;
	logic       idle;

	addr_t       exp_addr_q[$];	// Expected AW order
	data_t       exp_data_q[$];	// Expected W order
	int          pend_q[$];	// AW accepted, not yet answered
	int          errors;
	int          timeouts;
	int          aw_seen;
	int          w_seen;
	int          b_seen;
	int          done_seen;
	int          err_seen;
	int          ok_sent;
	int          err_sent;
	int          outstanding;
	int          pushed;	// Strobes taken into the queue
	int          popped;	// Pairs taken by the issuer
	logic        prev_valid;	// AW or W valid last cycle
	logic        resp_done;
	logic        hold_aw;	// AW valid without ready last cycle
	logic        hold_w;
	addr_t       held_addr;
	data_t       held_data;

	evict_top dut (
		.clk          (clk),
		.rst_n        (rst_n),
		.evict_i      (evict),
		.evict_req_i  (evict_req),
		.evict_full_o (evict_full),
		.awaddr_o     (awaddr),
		.awvalid_o    (awvalid),
		.awready_i    (awready),
		.wdata_o      (wdata),
		.wvalid_o     (wvalid),
		.wready_i     (wready),
		.bvalid_i     (bvalid),
		.bresp_i      (bresp),
		.bready_o     (bready),
		.wr_done_o    (wr_done),
		.wr_err_o     (wr_err),
		.idle_o       (idle)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic check_addr(input string what, input addr_t got, input addr_t exp);
		if (got !== exp) begin
			$display("FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic check_data(input string what, input data_t got, input data_t exp);
		if (got !== exp) begin
			$display("FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic check_flag(input string what, input logic got, input logic exp);
		if (got !== exp) begin
			$display("FAILED at %0t: %s is %b, expected %b", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic check_count(input string what, input int got, input int exp);
		if (got != exp) begin
			$display("FAILED at %0t: %s is %0d, expected %0d", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic finish_run();
		$display("Summary: %0d errors, %0d timeouts, %0d AW, %0d W, %0d B handshakes",
			errors, timeouts, aw_seen, w_seen, b_seen);
		if (errors == 0 && timeouts == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	endtask

	task automatic abort_run(input string what);
		$display("Timeout at %0t: %s for %0d cycles", $time, what, TIMEOUT);
		timeouts++;
		finish_run();
	endtask

	// Cache side, one strobe per eviction, never while full
	task automatic send_evictions();
		evict_req_t req;
		int         waited;
		int         gap;
		for (int i = 0; i < NUM_EVICT; i++) begin
			waited = 0;
			while (evict_full) begin
				@(posedge clk);
				#1;
				waited++;
				if (waited >= TIMEOUT) abort_run("evict_full_o stayed high");
			end
			req.addr  = $urandom;
			req.data  = {$urandom, $urandom};
			evict     = 1'b1;
			evict_req = req;
			exp_addr_q.push_back(req.addr);
			exp_data_q.push_back(req.data);
			@(posedge clk);
			#1;
			evict = 1'b0;
			gap   = $urandom_range(0, 2);
			repeat (gap) begin
				@(posedge clk);
				#1;
			end
		end
	endtask

	task automatic drive_ready();
		while (!resp_done) begin
			awready = ($urandom_range(0, 99) < 60);	// 60 percent ready
			wready  = ($urandom_range(0, 99) < 60);
			@(posedge clk);
			#1;
		end
	endtask

	// In-order B responses for accepted writes
	task automatic answer_writes();
		bresp_t code;
		int     waited;
		int     gap;
		for (int i = 0; i < NUM_EVICT; i++) begin
			waited = 0;
			while (pend_q.size() == 0) begin
				@(posedge clk);
				#1;
				waited++;
				if (waited >= TIMEOUT) abort_run("no accepted write to answer");
			end
			gap = $urandom_range(0, 3);
			repeat (gap) begin
				@(posedge clk);
				#1;
			end
			code   = bresp_t'($urandom_range(0, 3));
			bvalid = 1'b1;
			bresp  = code;
			waited = 0;
			@(negedge clk);
			while (!bready) begin
				waited++;
				if (waited >= TIMEOUT) abort_run("bready_o stayed low");
				@(negedge clk);
			end
			@(posedge clk);	// Handshake edge
			#1;
			void'(pend_q.pop_front());
			if (code == OKAY || code == EXOKAY) ok_sent++;
			else err_sent++;
			bvalid = 1'b0;
		end
		resp_done = 1'b1;
	endtask

	// Monitor, sampled mid-cycle where all outputs are settled
	always @(negedge clk) begin
		if (rst_n) begin
			if ((awvalid || wvalid) && !prev_valid) popped++;	// Pair left the queue last edge
			check_flag("evict_full_o", evict_full, (pushed - popped) == FIFO_DEPTH);
			check_flag("idle_o", idle,
				(pushed == popped) && !awvalid && !wvalid && (outstanding == 0));
			if (hold_aw) begin
				if (!awvalid) begin
					$display("Protocol error at %0t: awvalid dropped before handshake", $time);
					errors++;
				end
				check_addr("awaddr under stall", awaddr, held_addr);
			end
			if (hold_w) begin
				if (!wvalid) begin
					$display("Protocol error at %0t: wvalid dropped before handshake", $time);
					errors++;
				end
				check_data("wdata under stall", wdata, held_data);
			end
			if (awvalid && awready) begin
				if (exp_addr_q.size() == 0) begin
					$display("Protocol error at %0t: AW handshake with nothing queued", $time);
					errors++;
				end else begin
					check_addr("AW address", awaddr, exp_addr_q.pop_front());
				end
				pend_q.push_back(aw_seen);
				aw_seen++;
				outstanding++;
			end
			if (wvalid && wready) begin
				if (exp_data_q.size() == 0) begin
					$display("Protocol error at %0t: W handshake with nothing queued", $time);
					errors++;
				end else begin
					check_data("W data", wdata, exp_data_q.pop_front());
				end
				w_seen++;
			end
			if (bvalid && bready) begin
				b_seen++;
				outstanding--;
			end
			if (outstanding > MAX_OUTSTANDING) begin
				$display("Credit error at %0t: %0d writes outstanding", $time, outstanding);
				errors++;
			end
			if (wr_done) done_seen++;
			if (wr_err) err_seen++;
			if (evict) pushed++;	// Lands in the queue at the next edge
			prev_valid = awvalid || wvalid;
			hold_aw    = awvalid && !awready;
			hold_w     = wvalid && !wready;
			held_addr  = awaddr;
			held_data  = wdata;
		end
	end

	initial begin
		int waited;
		rst_n       = 1'b0;
		evict       = 1'b0;
		evict_req   = '0;
		awready     = 1'b0;
		wready      = 1'b0;
		bvalid      = 1'b0;
		bresp       = OKAY;
		errors      = 0;
		timeouts    = 0;
		aw_seen     = 0;
		w_seen      = 0;
		b_seen      = 0;
		done_seen   = 0;
		err_seen    = 0;
		ok_sent     = 0;
		err_sent    = 0;
		outstanding = 0;
		pushed      = 0;
		popped      = 0;
		prev_valid  = 1'b0;
		resp_done   = 1'b0;
		hold_aw     = 1'b0;
		hold_w      = 1'b0;
		void'($urandom(84));
		repeat (5) @(posedge clk);
		#1;
		rst_n = 1'b1;
		fork
			send_evictions();
			drive_ready();
			answer_writes();
		join
		waited = 0;
		@(negedge clk);
		while (!idle) begin
			waited++;
			if (waited >= TIMEOUT) abort_run("idle_o stayed low after the last response");
			@(negedge clk);
		end
		repeat (2) @(negedge clk);	// Let the last status pulse be counted
		#1;
		check_count("addresses left in model", exp_addr_q.size(), 0);
		check_count("data left in model", exp_data_q.size(), 0);
		check_count("AW handshakes", aw_seen, NUM_EVICT);
		check_count("W handshakes", w_seen, NUM_EVICT);
		check_count("wr_done_o pulses", done_seen, ok_sent);
		check_count("wr_err_o pulses", err_seen, err_sent);
		finish_run();
	end

endmodule

// ==== verilog.f ====
rtl/evict_pkg.sv
rtl/evict_fifo.sv
rtl/evict_queue.sv
rtl/evict_aw_w.sv
rtl/evict_bresp.sv
rtl/evict_top.sv
test/evict_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the eviction write-back testbench with Verilator

LOG=sim.log
BIN=obj_dir/Vevict_tb

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 -Wno-fatal \
	--timescale 1ns/10ps \
	--top-module evict_tb \
	-f verilog.f
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "TEST FAILED" "$LOG"; then
	echo "Simulation reported failure"
	exit 1
fi

echo "Simulation passed"
exit 0
